// ==== logic/i2c_slave_defines.svh ====
// ======================================================================
// Target address base, register map limits, widths and
// synchronizer depth for the I2C target
// ======================================================================
`ifndef I2C_SLAVE_DEFINES_SVH
`define I2C_SLAVE_DEFINES_SVH

// Device address 0x08..0x0F, low three bits come from the select pins
`define I2C_ADDR_BASE   7'h08

// Highest register index that gets an ACK
`define I2C_REG_LAST    8'h24

// Read-only window, inclusive
`define I2C_RO_FIRST    8'h03
`define I2C_RO_LAST     8'h05

`define I2C_DATA_W      8       // Byte on the wire
`define I2C_REG_ADDR_W  6       // Register index into the memory

// Flops per input synchronizer chain
`define I2C_SYNC_STAGES 3

`endif

// ==== logic/i2c_slave_pkg.sv ====
// ======================================================================
// Shared types for the I2C target, byte, register index, FSM state
// ======================================================================
`include "i2c_slave_defines.svh"

package i2c_slave_pkg;

    typedef logic [`I2C_DATA_W-1:0]     i2c_byte_t;   // Shift and data byte
    typedef logic [`I2C_REG_ADDR_W-1:0] reg_addr_t;   // Latched register index

    // Protocol states, one per bit phase of the transfer
    typedef enum logic [3:0] {
        IDLE,       // Bus free or not addressed
        DEV_ADDR,   // Seven address bits
        R_W,        // Direction bit
        ACK_ADDR,   // Address ACK
        DEV_REG,    // Register index byte
        ACK_REG,    // Register index ACK
        DATA_W,     // Write data byte
        ACK_DATA,   // Write data ACK
        DATA_R,     // Read data byte, target drives
        NACK,       // Target releases for one bit
        WAIT        // Released until STOP or repeated START
    } i2c_state_t;

endpackage

// ==== logic/i2c_line_monitor.sv ====
// ======================================================================
// SCL/SDA synchronizers, SCL edge flags, START and STOP detect
// ======================================================================
`timescale 1ns/1ps
`include "i2c_slave_defines.svh"

module i2c_line_monitor (
    input  logic clk,
    input  logic rst_n,
    input  logic scl,
    input  logic sda,
    output logic sda_sync,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det
);

    localparam int STAGES = `I2C_SYNC_STAGES;

    logic [STAGES-1:0] scl_sr;  // Newest sample in bit 0
    logic [STAGES-1:0] sda_sr;
    logic              scl_now;
    logic              scl_old;
    logic              sda_now;
    logic              sda_old;

    // Last two stages give the edge window
    assign scl_now  = scl_sr[STAGES-2];
    assign scl_old  = scl_sr[STAGES-1];
    assign sda_now  = sda_sr[STAGES-2];
    assign sda_old  = sda_sr[STAGES-1];
    assign sda_sync = sda_old;          // Lines up with the registered flags

    // ==================================================================
    // Synchronizer chains
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_sr <= '1;               // Bus idles high
            sda_sr <= '1;
        end else begin
            scl_sr <= {scl_sr[STAGES-2:0], scl};
            sda_sr <= {sda_sr[STAGES-2:0], sda};
        end
    end

    // Single-cycle flags, three clocks behind the pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else begin
            scl_rise  <= scl_now && !scl_old;
            scl_fall  <= !scl_now && scl_old;
            // SDA may only move with SCL high on START or STOP
            start_det <= scl_now && scl_old && sda_old && !sda_now;
            stop_det  <= scl_now && scl_old && !sda_old && sda_now;
        end
    end

    // SCL and SDA never move between the same two samples
    a_scl_sda_apart : assert property (
        @(posedge clk) disable iff (!rst_n)
            !((scl_now != scl_old) && (sda_now != sda_old))
    );

endmodule

// ==== logic/i2c_slave_fsm.sv ====
// ======================================================================
// I2C target protocol FSM with bit counter, receive shift register,
// device address match, ACK drive and read data shifter
// ======================================================================
`timescale 1ns/1ps
`include "i2c_slave_defines.svh"

module i2c_slave_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [2:0]               addr_sel,
    input  logic                     sda_sync,
    input  logic                     scl_rise,
    input  logic                     scl_fall,
    input  logic                     start_det,
    input  logic                     stop_det,
    input  logic                     reg_in_range,
    input  logic                     reg_read_only,
    input  i2c_slave_pkg::i2c_byte_t data_in,
    output i2c_slave_pkg::i2c_byte_t shift_byte,
    output logic                     addr_load,
    output logic                     data_load,
    output logic                     read_load,
    output logic                     sda_drive_low
);

    import i2c_slave_pkg::*;

    localparam logic [3:0] ADDR_BITS   = 4'd7;  // Address bits before R/W
    localparam logic [3:0] BYTE_BITS   = 4'd8;
    localparam logic [3:0] LAST_TX_BIT = 4'd7;  // Falls counted before bit 0 ends

    i2c_state_t state;
    i2c_state_t next_state;
    logic [3:0] bit_cnt;
    logic       rw_bit;         // 1 for a read
    logic [6:0] own_addr;
    logic       addr_match;
    logic       byte_done;      // SCL fall after the eighth bit
    logic       shift_rx;
    logic       ack_next;
    logic       tx_load;        // Same cycle as the external read strobe
    i2c_byte_t  tx_byte;

    // Select pins fill the low address bits
    assign own_addr   = `I2C_ADDR_BASE | {4'b0000, addr_sel};
    assign addr_match = (shift_byte[6:0] == own_addr);
    assign byte_done  = scl_fall && (bit_cnt == BYTE_BITS);
    assign shift_rx   = scl_rise && (state inside {DEV_ADDR, DEV_REG, DATA_W});
    assign ack_next   = next_state inside {ACK_ADDR, ACK_REG, ACK_DATA};

    // Load pulses to the register port, on the SCL fall that ends a phase
    assign addr_load = (state == DEV_REG) && byte_done && reg_in_range;
    assign data_load = (state == DATA_W) && byte_done && !reg_read_only;
    assign read_load = (state == ACK_ADDR) && scl_fall && rw_bit;

    // ==================================================================
    // Next state
    // ==================================================================
    always_comb begin
        next_state = state;
        if (stop_det) begin
            next_state = IDLE;                  // STOP wins from anywhere
        end else if (start_det) begin
            next_state = DEV_ADDR;              // START or repeated START
        end else begin
            case (state)
                IDLE: next_state = IDLE;
                DEV_ADDR: begin
                    if (scl_fall && bit_cnt == ADDR_BITS) next_state = R_W;
                end
                R_W: begin
                    if (scl_fall) next_state = addr_match ? ACK_ADDR : NACK;
                end
                ACK_ADDR: begin
                    if (scl_fall) next_state = rw_bit ? DATA_R : DEV_REG;
                end
                DEV_REG: begin
                    if (byte_done) next_state = reg_in_range ? ACK_REG : NACK;
                end
                ACK_REG: begin
                    if (scl_fall) next_state = DATA_W;
                end
                DATA_W: begin
                    if (byte_done) next_state = reg_read_only ? NACK : ACK_DATA;
                end
                ACK_DATA: begin
                    if (scl_fall) next_state = WAIT;
                end
                DATA_R: begin
                    // Controller answers the byte, target lets go
                    if (scl_fall && bit_cnt == LAST_TX_BIT) next_state = WAIT;
                end
                NACK: begin
                    if (scl_fall) next_state = WAIT;
                end
                WAIT: next_state = WAIT;        // Only STOP or START leave
                default: next_state = IDLE;
            endcase
        end
    end

    // ==================================================================
    // State, counters and SDA drive
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            bit_cnt       <= 4'd0;
            rw_bit        <= 1'b0;
            tx_load       <= 1'b0;
            sda_drive_low <= 1'b0;
        end else begin
            state   <= next_state;
            tx_load <= read_load;

            // Count restarts on every phase change
            if (start_det || stop_det || next_state != state) begin
                bit_cnt <= 4'd0;
            end else if (shift_rx) begin
                bit_cnt <= bit_cnt + 4'd1;      // Receive bits on SCL rise
            end else if (state == DATA_R && scl_fall) begin
                bit_cnt <= bit_cnt + 4'd1;      // Transmit bits on SCL fall
            end

            if (state == R_W && scl_rise) begin
                rw_bit <= sda_sync;
            end

            // ACK from the fall after bit 8 to the next fall
            if (ack_next) begin
                sda_drive_low <= 1'b1;
            end else if (next_state != DATA_R || state != DATA_R) begin
                sda_drive_low <= 1'b0;          // Released in all other phases
            end else if (tx_load) begin
                sda_drive_low <= ~data_in[`I2C_DATA_W-1];   // MSB first
            end else if (scl_fall) begin
                sda_drive_low <= ~tx_byte[`I2C_DATA_W-2];   // Next bit out
            end
        end
    end

    // Receive shifter, address, index and data all pass through it
    always_ff @(posedge clk) begin
        if (shift_rx) begin
            shift_byte <= {shift_byte[`I2C_DATA_W-2:0], sda_sync};
        end
    end

    // Transmit shifter for the read byte
    always_ff @(posedge clk) begin
        if (tx_load) begin
            tx_byte <= data_in;
        end else if (state == DATA_R && scl_fall) begin
            tx_byte <= {tx_byte[`I2C_DATA_W-2:0], 1'b0};
        end
    end

    // Bus is never pulled while the target is unaddressed
    a_idle_released : assert property (
        @(posedge clk) disable iff (!rst_n) (state == IDLE) |-> !sda_drive_low
    );

endmodule

// ==== logic/i2c_reg_port.sv ====
// ======================================================================
// Register index latch with range and read-only decode,
// write data latch and the external access strobes
// ======================================================================
`timescale 1ns/1ps
`include "i2c_slave_defines.svh"

module i2c_reg_port (
    input  logic                     clk,
    input  logic                     rst_n,
    input  i2c_slave_pkg::i2c_byte_t shift_byte,
    input  logic                     addr_load,
    input  logic                     data_load,
    input  logic                     read_load,
    output logic                     reg_in_range,
    output logic                     reg_read_only,
    output i2c_slave_pkg::reg_addr_t reg_addr,
    output i2c_slave_pkg::i2c_byte_t data_out,
    output logic                     reg_write,
    output logic                     reg_read
);

    import i2c_slave_pkg::*;

    i2c_byte_t addr_ext;        // Latched index widened for the compare

    // ==================================================================
    // Decodes
    // ==================================================================
    // Full incoming byte, so 0x40 and above also fail
    assign reg_in_range = (shift_byte <= `I2C_REG_LAST);

    assign addr_ext      = i2c_byte_t'(reg_addr);
    assign reg_read_only = (addr_ext >= `I2C_RO_FIRST) &&
                           (addr_ext <= `I2C_RO_LAST);

    // ==================================================================
    // Latches and strobes, one clock behind the load pulses
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_addr  <= '0;
            data_out  <= '0;
            reg_write <= 1'b0;
            reg_read  <= 1'b0;
        end else begin
            reg_write <= data_load;
            reg_read  <= read_load;
            if (addr_load) begin
                // Out of range bytes never load, old index stays
                reg_addr <= shift_byte[`I2C_REG_ADDR_W-1:0];
            end
            if (data_load) begin
                data_out <= shift_byte;         // Valid with the write strobe
            end
        end
    end

    // One access per transfer, a read and a write never overlap
    a_rw_excl : assert property (
        @(posedge clk) disable iff (!rst_n) !(reg_write && reg_read)
    );

    // The FSM keeps write strobes off the read-only window
    a_no_ro_write : assert property (
        @(posedge clk) disable iff (!rst_n) reg_write |-> !reg_read_only
    );

endmodule

// ==== logic/i2c_slave_top.sv ====
// ======================================================================
// I2C target top, line monitor, protocol FSM and register port
// ======================================================================
`timescale 1ns/1ps

module i2c_slave_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     scl,
    input  logic                     sda,
    input  logic [2:0]               addr_sel,
    input  i2c_slave_pkg::i2c_byte_t data_in,
    output logic                     sda_drive_low,
    output i2c_slave_pkg::reg_addr_t reg_addr,
    output i2c_slave_pkg::i2c_byte_t data_out,
    output logic                     reg_write,
    output logic                     reg_read
);

    import i2c_slave_pkg::*;

    // Monitor to FSM
    logic      sda_sync;
    logic      scl_rise;
    logic      scl_fall;
    logic      start_det;
    logic      stop_det;

    // FSM and register port handshake
    i2c_byte_t shift_byte;
    logic      addr_load;
    logic      data_load;
    logic      read_load;
    logic      reg_in_range;
    logic      reg_read_only;

    i2c_line_monitor i2c_line_monitor_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl       (scl),
        .sda       (sda),
        .sda_sync  (sda_sync),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det)
    );

    i2c_slave_fsm i2c_slave_fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr_sel      (addr_sel),
        .sda_sync      (sda_sync),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .start_det     (start_det),
        .stop_det      (stop_det),
        .reg_in_range  (reg_in_range),
        .reg_read_only (reg_read_only),
        .data_in       (data_in),
        .shift_byte    (shift_byte),
        .addr_load     (addr_load),
        .data_load     (data_load),
        .read_load     (read_load),
        .sda_drive_low (sda_drive_low)
    );

    i2c_reg_port i2c_reg_port_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .shift_byte    (shift_byte),
        .addr_load     (addr_load),
        .data_load     (data_load),
        .read_load     (read_load),
        .reg_in_range  (reg_in_range),
        .reg_read_only (reg_read_only),
        .reg_addr      (reg_addr),
        .data_out      (data_out),
        .reg_write     (reg_write),
        .reg_read      (reg_read)
    );

endmodule

// ==== tests/i2c_master_tasks.svh ====
// ======================================================================
// I2C controller tasks, START, STOP, bit and byte transfer with ACK
// ======================================================================

// All bus changes land on falling clock edges
task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
endtask

// START from idle, or repeated START when SCL is low
task automatic bus_start();
    if (!scl) begin
        wait_clks(2);
        sda_m = 1'b1;                   // Release SDA while SCL is low
        wait_clks(SCL_HALF - 2);
        scl = 1'b1;
        wait_clks(SCL_HALF);
    end
    sda_m = 1'b0;                       // SDA falls with SCL high
    wait_clks(SCL_HALF);
    scl = 1'b0;
endtask

// STOP, ends with both lines high
task automatic bus_stop();
    wait_clks(2);
    sda_m = 1'b0;
    wait_clks(SCL_HALF - 2);
    scl = 1'b1;
    wait_clks(SCL_HALF);
    sda_m = 1'b1;                       // SDA rises with SCL high
    wait_clks(SCL_HALF);
endtask

// One SCL pulse, SDA set a little after the SCL fall
task automatic send_bit(input logic b);
    wait_clks(2);                       // Hold after the fall
    sda_m = b;
    wait_clks(SCL_HALF - 2);
    scl = 1'b1;
    wait_clks(SCL_HALF);
    scl = 1'b0;
endtask

// Controller releases SDA and samples the wired bus
task automatic recv_bit(output logic b);
    wait_clks(2);
    sda_m = 1'b1;
    wait_clks(SCL_HALF - 2);
    scl = 1'b1;
    wait_clks(SCL_HALF / 2);
    b = sda_bus;                        // Middle of SCL high
    wait_clks(SCL_HALF / 2);
    scl = 1'b0;
endtask

// Byte out MSB first, ack is the ninth bit as seen on the bus (0 = ACK)
task automatic send_byte(input logic [7:0] data, output logic ack);
    for (int i = 7; i >= 0; i--) begin
        send_bit(data[i]);
    end
    recv_bit(ack);
endtask

// Byte in MSB first, then the controller's answer bit
task automatic recv_byte(output logic [7:0] data, input logic nack);
    logic b;
    data = 8'h00;
    for (int i = 0; i < 8; i++) begin
        recv_bit(b);
        data = {data[6:0], b};          // Shift in, MSB arrives first
    end
    send_bit(nack);
endtask

// ==== tests/tb_i2c_slave.sv ====
// ======================================================================
// Testbench for the I2C target with random transfers, a register
// memory model, strobe monitors and a cycle timeout
// ======================================================================
`timescale 1ns/1ps

module tb_i2c_slave;

    localparam int SCL_HALF   = 8;      // clk cycles per SCL phase
    localparam int NUM_TXN    = 40;
    localparam int MAX_CYCLES = NUM_TXN * 40 * 2 * SCL_HALF;   // 40 SCL periods each

    logic        clk = 1'b0;
    logic        rst_n;
    logic        scl;
    logic        sda_m;                 // Controller side of the wired-AND
    logic        sda_bus;
    logic [2:0]  addr_sel;
    logic [7:0]  data_in;
    logic        sda_drive_low;
    logic [5:0]  reg_addr;
    logic [7:0]  data_out;
    logic        reg_write;
    logic        reg_read;

    logic [7:0]  mem [64];              // Register memory model
    logic [31:0] rng;
    logic [5:0]  exp_ptr;               // Last index the target accepted
    int          wr_count;
    int          rd_count;
    logic [5:0]  wr_addr_seen;
    logic [7:0]  wr_data_seen;
    int          cycles;

    assign sda_bus = sda_m & ~sda_drive_low;    // Open-drain bus
    assign data_in = mem[reg_addr];             // Combinational register read

    i2c_slave_top i2c_slave_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .scl           (scl),
        .sda           (sda_bus),
        .addr_sel      (addr_sel),
        .data_in       (data_in),
        .sda_drive_low (sda_drive_low),
        .reg_addr      (reg_addr),
        .data_out      (data_out),
        .reg_write     (reg_write),
        .reg_read      (reg_read)
    );

    `include "i2c_master_tasks.svh"

    always #2 clk = ~clk;               // 4 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expect_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // ==================================================================
    // Memory model and strobe monitor, sampled on falling edges
    // ==================================================================
    initial begin
        wr_count     = 0;
        rd_count     = 0;
        wr_addr_seen = 6'd0;
        wr_data_seen = 8'd0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 8'(i * 37 + 11);   // Distinct per index
        end
        forever begin
            @(negedge clk);
            if (reg_write) begin
                wr_count      = wr_count + 1;
                wr_addr_seen  = reg_addr;
                wr_data_seen  = data_out;
                mem[reg_addr] = data_out;
            end
            if (reg_read) begin
                rd_count = rd_count + 1;
            end
        end
    end

    // One transfer: 0 write, 1 read, 2 index write then repeated START read
    task automatic run_transaction(input int n);
        logic [1:0] op;
        logic [6:0] dev;
        logic [7:0] reg_b;
        logic [7:0] data_b;
        logic [7:0] rd_b;
        logic       ack;
        logic       dev_ok;
        logic       reg_ok;
        logic       wr_exp;
        logic       rd_exp;
        int         wr0;
        int         rd0;
        string      tag;

        rng    = xorshift32(rng);
        op     = 2'(rng % 32'd3);
        rng    = xorshift32(rng);
        dev    = (rng[1:0] != 2'b00) ? (7'h08 + 7'(addr_sel)) : rng[14:8];
        reg_b  = {2'b00, rng[21:16]};
        data_b = rng[31:24];
        tag    = $sformatf("txn %0d", n);
        dev_ok = (dev == 7'h08 + 7'(addr_sel));
        reg_ok = (reg_b <= 8'h24);
        wr_exp = 1'b0;
        rd_exp = 1'b0;
        wr0    = wr_count;
        rd0    = rd_count;

        bus_start();
        send_byte({dev, op == 2'd1}, ack);
        expect_value({tag, " addr ack"}, int'(!dev_ok), int'(ack));
        if (dev_ok && op == 2'd1) begin
            rd_exp = 1'b1;
            recv_byte(rd_b, 1'b1);      // Controller NACKs the single byte
            expect_value({tag, " read data"}, int'(mem[exp_ptr]), int'(rd_b));
        end else if (dev_ok) begin
            send_byte(reg_b, ack);
            expect_value({tag, " reg ack"}, int'(!reg_ok), int'(ack));
            if (reg_ok) begin
                exp_ptr = reg_b[5:0];
            end
            if (op == 2'd0) begin
                // Registers 3..5 are read-only
                wr_exp = reg_ok && !(reg_b >= 8'h03 && reg_b <= 8'h05);
                send_byte(data_b, ack);
                expect_value({tag, " data ack"}, int'(!wr_exp), int'(ack));
            end else begin
                rd_exp = 1'b1;
                bus_start();            // Repeated START
                send_byte({dev, 1'b1}, ack);
                expect_value({tag, " read addr ack"}, 0, int'(ack));
                recv_byte(rd_b, 1'b1);
                expect_value({tag, " read data"}, int'(mem[exp_ptr]), int'(rd_b));
            end
        end
        bus_stop();
        wait_clks(SCL_HALF);            // STOP and strobes have settled

        expect_value({tag, " write strobes"}, int'(wr_exp), wr_count - wr0);
        expect_value({tag, " read strobes"}, int'(rd_exp), rd_count - rd0);
        if (wr_exp) begin
            expect_value({tag, " write addr"}, int'(exp_ptr), int'(wr_addr_seen));
            expect_value({tag, " write data"}, int'(data_b), int'(wr_data_seen));
        end
        expect_value({tag, " reg_addr"}, int'(exp_ptr), int'(reg_addr));
    endtask

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        rst_n    = 1'b0;
        scl      = 1'b1;                // Bus idle
        sda_m    = 1'b1;
        addr_sel = 3'd0;
        rng      = 32'h5d2e;
        exp_ptr  = 6'd0;
        wait_clks(2);
        rst_n = 1'b1;
        wait_clks(1);

        expect_value("reset reg_write", 0, int'(reg_write));
        expect_value("reset reg_read", 0, int'(reg_read));
        expect_value("reset sda_drive_low", 0, int'(sda_drive_low));
        expect_value("reset reg_addr", 0, int'(reg_addr));
        expect_value("reset data_out", 0, int'(data_out));

        for (int n = 0; n < NUM_TXN; n++) begin
            rng      = xorshift32(rng);
            addr_sel = rng[2:0];        // Changes only with the bus idle
            wait_clks(SCL_HALF);
            run_transaction(n);
        end
        $display("test passed");
        $finish;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout, transfers did not finish within %0d cycles", MAX_CYCLES);
        $display("test failed");
        $fatal(1);
    end

endmodule

// ==== list.f ====
+incdir+logic
+incdir+tests
logic/i2c_slave_pkg.sv
logic/i2c_line_monitor.sv
logic/i2c_slave_fsm.sv
logic/i2c_reg_port.sv
logic/i2c_slave_top.sv
tests/tb_i2c_slave.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the I2C target testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f list.f --top-module tb_i2c_slave -Mdir "$BUILD_DIR"; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_i2c_slave" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
